// File: rtl/uart_pkg.sv
package uart_pkg;

    // one serial data byte.
    typedef logic [7:0] byte_t;

    // parity mode shared by transmitter and receiver.
    typedef enum logic [1:0] {
        parity_none = 2'd0,
        parity_even = 2'd1,
        parity_odd  = 2'd2
    } parity_e;

    // transmitter frame position.
    typedef enum logic [2:0] {
        txs_idle   = 3'd0,
        txs_start  = 3'd1,
        txs_data   = 3'd2,
        txs_parity = 3'd3,
        txs_stop   = 3'd4
    } tx_state_e;

    // receiver frame position.
    typedef enum logic [2:0] {
        rxs_idle   = 3'd0,
        rxs_start  = 3'd1,
        rxs_data   = 3'd2,
        rxs_parity = 3'd3,
        rxs_stop   = 3'd4
    } rx_state_e;

    // byte sequencer steps.
    typedef enum logic [1:0] {
        seq_init      = 2'd0,
        seq_launch    = 2'd1,
        seq_wait_busy = 2'd2,
        seq_wait_idle = 2'd3
    } seq_state_e;

    // one received byte with its error flags, 10 bits in all.
    typedef struct packed {
        byte_t data;
        logic  parity_error;
        logic  frame_error;
    } rx_status_t;

endpackage

// File: rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; #(
    parameter int      CLKS_PER_BIT = 8,
    parameter parity_e PARITY       = parity_even
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  tx_start,
    input  byte_t tx_data,
    output logic  txd,
    output logic  tx_busy
);

    // bit-period counter width, at least one bit.
    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    tx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_reg;
    logic             par_bit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= txs_idle;
            txd     <= 1'b1;
            tx_busy <= 1'b0;
        end else begin
            case (state)
                txs_idle: begin
                    // a strobe is only taken while idle.
                    if (tx_start) begin
                        state     <= txs_start;
                        txd       <= 1'b0;
                        tx_busy   <= 1'b1;
                        cnt       <= '0;
                        shift_reg <= tx_data;
                        // odd mode inverts the plain xor.
                        par_bit   <= (^tx_data) ^ (PARITY == parity_odd);
                    end
                end
                default: begin
                    if (cnt != BIT_LAST) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        // end of the current bit period.
                        cnt <= '0;
                        case (state)
                            txs_start: begin
                                state   <= txs_data;
                                bit_idx <= '0;
                                txd     <= shift_reg[0];
                            end
                            txs_data: begin
                                if (bit_idx == 3'd7) begin
                                    if (PARITY != parity_none) begin
                                        state <= txs_parity;
                                        txd   <= par_bit;
                                    end else begin
                                        state <= txs_stop;
                                        txd   <= 1'b1;
                                    end
                                end else begin
                                    // lsb first, next bit moves to position 0.
                                    bit_idx   <= bit_idx + 1'b1;
                                    shift_reg <= shift_reg >> 1;
                                    txd       <= shift_reg[1];
                                end
                            end
                            txs_parity: begin
                                state <= txs_stop;
                                txd   <= 1'b1;
                            end
                            default: begin
                                // stop bit done, line stays high.
                                state   <= txs_idle;
                                tx_busy <= 1'b0;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
    parameter int      CLKS_PER_BIT = 8,
    parameter parity_e PARITY       = parity_even
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic       rx_valid,
    output rx_status_t rx_status
);

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    // first sample lands half a bit after the edge.
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);

    rx_state_e        state;
    logic [1:0]       sync;
    logic             rxd_prev;
    logic             rxd_s;
    logic             fall;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_reg;
    logic             par_acc;
    logic             par_err;

    // synchronized line and its falling edge.
    assign rxd_s = sync[1];
    assign fall  = rxd_prev & ~rxd_s;

    always_ff @(posedge clk) begin
        if (rst) begin
            // idle line is high.
            sync      <= 2'b11;
            rxd_prev  <= 1'b1;
            state     <= rxs_idle;
            rx_valid  <= 1'b0;
            rx_status <= '0;
        end else begin
            sync     <= {sync[0], rxd};
            rxd_prev <= rxd_s;
            rx_valid <= 1'b0;
            case (state)
                rxs_idle: begin
                    if (fall) begin
                        state <= rxs_start;
                        cnt   <= '0;
                    end
                end
                rxs_start: begin
                    if (cnt != HALF_LAST) begin
                        cnt <= cnt + 1'b1;
                    end else if (rxd_s) begin
                        // high at mid start bit, a glitch.
                        state <= rxs_idle;
                    end else begin
                        state   <= rxs_data;
                        cnt     <= '0;
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                        par_err <= 1'b0;
                    end
                end
                default: begin
                    if (cnt != BIT_LAST) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        // mid-bit sample point.
                        cnt <= '0;
                        case (state)
                            rxs_data: begin
                                shift_reg <= {rxd_s, shift_reg[7:1]};
                                par_acc   <= par_acc ^ rxd_s;
                                bit_idx   <= bit_idx + 1'b1;
                                if (bit_idx == 3'd7) begin
                                    state <= (PARITY != parity_none) ? rxs_parity : rxs_stop;
                                end
                            end
                            rxs_parity: begin
                                // even mode expects a zero xor over data and parity.
                                par_err <= (par_acc ^ rxd_s) ^ (PARITY == parity_odd);
                                state   <= rxs_stop;
                            end
                            default: begin
                                rx_status.data         <= shift_reg;
                                rx_status.parity_error <= par_err;
                                rx_status.frame_error  <= ~rxd_s;
                                rx_valid               <= 1'b1;
                                state                  <= rxs_idle;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/pattern_sender.sv
`timescale 1ns/1ps

module pattern_sender import uart_pkg::*; #(
    parameter int STARTUP_CYCLES = 1000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  tx_busy,
    output logic  tx_start,
    output byte_t tx_data,
    output logic  ready
);

    // delay counter sized to hold the full delay.
    localparam int DLY_W = (STARTUP_CYCLES > 1) ? $clog2(STARTUP_CYCLES + 1) : 1;
    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(STARTUP_CYCLES - 1);

    seq_state_e       state;
    logic [DLY_W-1:0] dly_cnt;

    // one-cycle strobe while in launch.
    assign tx_start = (state == seq_launch);
    // ready stays high once the delay is over.
    assign ready    = (state != seq_init);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= seq_init;
            dly_cnt <= '0;
            tx_data <= '0;
        end else begin
            case (state)
                seq_init: begin
                    dly_cnt <= dly_cnt + 1'b1;
                    if (dly_cnt == DLY_LAST) begin
                        state <= seq_launch;
                    end
                end
                seq_launch: begin
                    // transmitter takes the byte on this edge.
                    state <= seq_wait_busy;
                end
                seq_wait_busy: begin
                    // busy rises one cycle after the strobe.
                    if (tx_busy) begin
                        state <= seq_wait_idle;
                    end
                end
                default: begin
                    // frame over, next byte wraps at 0xff.
                    if (!tx_busy) begin
                        tx_data <= tx_data + 1'b1;
                        state   <= seq_launch;
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; #(
    parameter int      CLKS_PER_BIT   = 8,
    parameter parity_e PARITY         = parity_even,
    parameter int      STARTUP_CYCLES = 1000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic       txd,
    output logic       ready,
    output logic       rx_valid,
    output rx_status_t rx_status
);

    // sequencer to transmitter handshake.
    logic  tx_start;
    logic  tx_busy;
    byte_t tx_data;

    // byte pattern after the start-up delay.
    pattern_sender #(
        .STARTUP_CYCLES (STARTUP_CYCLES)
    ) u_sender (
        .clk      (clk),
        .rst      (rst),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .ready    (ready)
    );

    // serial output path.
    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    // serial input path, status goes straight out.
    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY)
    ) u_rx (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .rx_valid  (rx_valid),
        .rx_status (rx_status)
    );

endmodule

// File: bench/uart_properties.sv
`timescale 1ns/1ps

module uart_properties import uart_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      tx_start,
    input logic      txd,
    input logic      tx_busy,
    input tx_state_e state
);

    // line rests high between frames.
    idle_line_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> txd)
        else $error("txd low while the transmitter is not busy");

    // sequencer waits for the frame to end.
    no_start_when_busy: assert property (@(posedge clk) disable iff (rst) tx_busy |-> !tx_start)
        else $error("tx_start issued while the transmitter was busy");

    // busy follows an accepted strobe by one cycle.
    busy_after_start: assert property (@(posedge clk) disable iff (rst)
        tx_start && !tx_busy |=> tx_busy)
        else $error("tx_busy did not rise after tx_start");

    // the start bit holds the line low.
    start_bit_low: assert property (@(posedge clk) disable iff (rst)
        (state == txs_start) |-> !txd)
        else $error("txd high during the start bit");

endmodule

bind uart_tx uart_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .txd      (txd),
    .tx_busy  (tx_busy),
    .state    (state)
);

// File: bench/uart_tb.sv
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

    localparam int CPB     = 8;
    localparam int STARTUP = 40;
    localparam int N_RAND  = 12;
    localparam int N_LOOP  = 6;
    // random frames, one bad parity, one bad stop, loopback frames and one to sync on.
    localparam int FRAMES  = N_RAND + 2 + N_LOOP + 1;
    // doubled to cover idle gaps between frames.
    localparam int TIMEOUT_CYCLES = 2 * (FRAMES * 11 * CPB + STARTUP) + 100;

    logic        clk;
    logic        rst;
    logic        drv_rxd;
    logic        loop_en;
    logic        rxd;
    logic        txd;
    logic        ready;
    logic        rx_valid;
    rx_status_t  rx_status;
    logic [31:0] lfsr;
    rx_status_t  exp_q[$];
    int          tx_frames;
    int          rx_count;

    // loopback wire makes the transmitter the serial source.
    assign rxd = loop_en ? txd : drv_rxd;

    uart_top #(
        .CLKS_PER_BIT   (CPB),
        .PARITY         (parity_even),
        .STARTUP_CYCLES (STARTUP)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .txd       (txd),
        .ready     (ready),
        .rx_valid  (rx_valid),
        .rx_status (rx_status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    // fibonacci lfsr with taps x^32+x^22+x^2+x+1 stepped once per bit taken.
    function automatic byte_t random_byte();
        byte_t b;
        for (int i = 0; i < 8; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            b[i] = lfsr[0];
        end
        return b;
    endfunction

    // line levels of one even-parity frame with the start bit at index 0.
    function automatic logic [10:0] frame_bits(input byte_t d);
        logic par;
        par = 1'b0;
        for (int i = 0; i < 8; i++) begin
            par = par ^ d[i];
        end
        return {1'b1, par, d, 1'b0};
    endfunction

    // a bad parity bit or a low stop bit shows up only in its own flag.
    function automatic rx_status_t expected_status(input byte_t d, input logic bad_par,
                                                   input logic bad_stop);
        return '{data: d, parity_error: bad_par, frame_error: bad_stop};
    endfunction

    task automatic send_frame(input byte_t d, input logic bad_par, input logic bad_stop);
        logic [10:0] bits;
        bits     = frame_bits(d);
        bits[9]  = bits[9] ^ bad_par;
        bits[10] = ~bad_stop;
        exp_q.push_back(expected_status(d, bad_par, bad_stop));
        for (int b = 0; b < 11; b++) begin
            repeat (CPB) begin
                @(posedge clk);
                drv_rxd <= bits[b];
            end
        end
        // two idle bit times.
        repeat (2 * CPB) begin
            @(posedge clk);
            drv_rxd <= 1'b1;
        end
    endtask

    // decodes txd at every falling clock edge, checking each cycle of each bit.
    initial begin : decode_txd
        byte_t       expect_tx;
        logic [10:0] bits;
        expect_tx = 8'h00;
        tx_frames = 0;
        forever begin
            do begin
                @(negedge clk);
            end while (rst || txd !== 1'b0);
            // loopback frames also reach the receiver.
            if (loop_en) begin
                exp_q.push_back(expected_status(expect_tx, 1'b0, 1'b0));
            end
            bits = frame_bits(expect_tx);
            for (int b = 0; b < 11; b++) begin
                for (int c = 0; c < CPB; c++) begin
                    if (b != 0 || c != 0) begin
                        @(negedge clk);
                    end
                    check_value("txd", 32'(txd), 32'(bits[b]));
                end
            end
            tx_frames++;
            expect_tx++;
        end
    end

    // each receive pulse matches the oldest expected status.
    always @(negedge clk) begin : compare_rx
        rx_status_t want;
        if (!rst && rx_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("receiver pulsed rx_valid with no frame sent to it");
            end else begin
                want = exp_q.pop_front();
                check_value("rx_status", 32'(rx_status), 32'(want));
                rx_count++;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("run timed out before all frames were received");
    end

    initial begin : main_seq
        int start_frames;
        rst      = 1'b1;
        drv_rxd  = 1'b1;
        loop_en  = 1'b0;
        lfsr     = 32'hc204_cb67;
        rx_count = 0;
        @(negedge clk);
        check_value("txd", 32'(txd), 32'd1);
        check_value("ready", 32'(ready), 32'd0);
        @(posedge clk);
        rst <= 1'b0;
        // quiet line until the start-up delay runs out.
        repeat (STARTUP) begin
            @(negedge clk);
            check_value("txd", 32'(txd), 32'd1);
            check_value("ready", 32'(ready), 32'd0);
        end
        @(negedge clk);
        check_value("ready", 32'(ready), 32'd1);
        for (int i = 0; i < N_RAND; i++) begin
            send_frame(random_byte(), 1'b0, 1'b0);
        end
        send_frame(random_byte(), 1'b1, 1'b0);
        send_frame(random_byte(), 1'b0, 1'b1);
        // the status pulse comes mid stop bit, well before the idle time ends.
        check_value("rx_count", 32'(rx_count), 32'(N_RAND + 2));
        // close the loop in the idle gap after a transmitted frame.
        start_frames = tx_frames;
        while (tx_frames == start_frames) begin
            @(posedge clk);
        end
        loop_en <= 1'b1;
        while (rx_count < N_RAND + 2 + N_LOOP) begin
            @(posedge clk);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: tb.f
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/pattern_sender.sv
rtl/uart_top.sv
bench/uart_properties.sv
bench/uart_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f tb.f \
    && ./obj_dir/Vuart_tb | tee /dev/stderr | grep -q 'All tests passed!' \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
